//--- design/la_pkg.sv
package la_pkg;

   // Capture geometry
   localparam int CAPTURE_DEPTH = 64;
   localparam int NUM_CHANNELS  = 9;
   localparam int COUNT_WIDTH   = $clog2(CAPTURE_DEPTH);

   // Register port
   localparam int BYTECNT_SIZE   = 3;
   localparam int REG_WORD_WIDTH = 8 * (2 ** BYTECNT_SIZE);  // Widest multi-byte register

   localparam logic [15:0] EXISTS_CODE = 16'h4C41;  // "LA"

   // Register addresses
   localparam logic [7:0] REG_EXISTS         = 8'd0;
   localparam logic [7:0] REG_CAPTURE_DEPTH  = 8'd1;
   localparam logic [7:0] REG_STATUS         = 8'd2;
   localparam logic [7:0] REG_TRIGGER_SOURCE = 8'd3;
   localparam logic [7:0] REG_CAPTURE_GROUP  = 8'd4;
   localparam logic [7:0] REG_READ_SELECT    = 8'd5;

   // Trigger sources
   localparam logic [1:0] TRIG_ADC        = 2'd0;
   localparam logic [1:0] TRIG_GLITCH_GO  = 2'd1;
   localparam logic [1:0] TRIG_GLITCH_SRC = 2'd2;
   localparam logic [1:0] TRIG_HS1        = 2'd3;

   // Probe groups
   localparam logic [1:0] GROUP_GLITCH   = 2'd0;
   localparam logic [1:0] GROUP_FRONT_IO = 2'd1;
   localparam logic [1:0] GROUP_USER_IO  = 2'd2;
   localparam logic [1:0] GROUP_3        = 2'd3;  // Fixed 1,0,1,0 test pattern

   // Returned for read selects past the last channel
   localparam logic [CAPTURE_DEPTH-1:0] FILL_PATTERN = 64'h0000_0000_000B_38F0;

endpackage

//--- design/la_regs.sv
`timescale 1ns/1ns

module la_regs (
   input  logic                           observer_clk,
   input  logic                           reset,
   input  logic [7:0]                     reg_address,
   input  logic [7:0]                     reg_datai,
   input  logic                           reg_read,
   input  logic                           reg_write,
   input  logic [la_pkg::BYTECNT_SIZE-1:0] reg_bytecnt,
   output logic [7:0]                     reg_datao,
   input  logic                           capturing,
   input  logic                           capture_done,
   input  logic [7:0]                     read_data,
   output logic [1:0]                     trigger_source,
   output logic [1:0]                     capture_group,
   output logic [3:0]                     read_select
);

   logic [la_pkg::REG_WORD_WIDTH-1:0] exists_word;
   logic [la_pkg::REG_WORD_WIDTH-1:0] depth_word;
   logic [la_pkg::BYTECNT_SIZE+2:0]   byte_lsb;
   logic                              done;
   logic                              capturing_d;

   // Multi-byte registers padded out to the full byte count range
   assign exists_word = {{(la_pkg::REG_WORD_WIDTH-16){1'b0}}, la_pkg::EXISTS_CODE};
   assign depth_word  = {{(la_pkg::REG_WORD_WIDTH-32){1'b0}}, la_pkg::CAPTURE_DEPTH};
   assign byte_lsb    = {reg_bytecnt, 3'b000};

   // Configuration writes
   always_ff @(posedge observer_clk) begin
      if (reset) begin
         trigger_source <= la_pkg::TRIG_ADC;
         capture_group  <= la_pkg::GROUP_GLITCH;
         read_select    <= 4'd0;
      end else if (reg_write) begin
         case (reg_address)
            la_pkg::REG_TRIGGER_SOURCE: trigger_source <= reg_datai[1:0];
            la_pkg::REG_CAPTURE_GROUP:  capture_group  <= reg_datai[1:0];
            la_pkg::REG_READ_SELECT:    read_select    <= reg_datai[3:0];
            default: ;  // Read-only or unmapped
         endcase
      end
   end

   // Sticky done flag, dropped when the next capture starts
   always_ff @(posedge observer_clk) begin
      if (reset) begin
         done        <= 1'b0;
         capturing_d <= 1'b0;
      end else begin
         capturing_d <= capturing;
         if (capturing && !capturing_d) begin
            done <= 1'b0;
         end else if (capture_done) begin
            done <= 1'b1;
         end
      end
   end

   // Registered read mux, one cycle latency
   always_ff @(posedge observer_clk) begin
      if (reset) begin
         reg_datao <= 8'd0;
      end else if (reg_read) begin
         case (reg_address)
            la_pkg::REG_EXISTS:         reg_datao <= exists_word[byte_lsb +: 8];
            la_pkg::REG_CAPTURE_DEPTH:  reg_datao <= depth_word[byte_lsb +: 8];
            la_pkg::REG_STATUS:         reg_datao <= {6'd0, capturing, done};
            la_pkg::REG_TRIGGER_SOURCE: reg_datao <= {6'd0, trigger_source};
            la_pkg::REG_CAPTURE_GROUP:  reg_datao <= {6'd0, capture_group};
            la_pkg::REG_READ_SELECT:    reg_datao <= read_data;  // Captured record byte
            default:                    reg_datao <= 8'd0;
         endcase
      end else begin
         reg_datao <= 8'd0;  // Idle bus reads zero
      end
   end

   // Host must not read and write in the same cycle
   a_no_read_write: assert property (
      @(posedge observer_clk) disable iff (reset)
      !(reg_read && reg_write)
   ) else $error("reg_read and reg_write high together");

endmodule

//--- design/la_trigger_sync.sv
`timescale 1ns/1ns

module la_trigger_sync (
   input  logic       observer_clk,
   input  logic       reset,
   input  logic [1:0] trigger_source,
   input  logic       adc_capture_go,
   input  logic       glitch_go,
   input  logic       glitch_trigger_src,
   input  logic       hs1,
   output logic       capture_go
);

   logic                           trig_async;
   (* ASYNC_REG = "TRUE" *) logic [1:0] trig_sync;  // Two-flop synchronizer
   logic [1:0]                     trig_delay;

   always_comb begin
      case (trigger_source)
         la_pkg::TRIG_ADC:        trig_async = adc_capture_go;
         la_pkg::TRIG_GLITCH_GO:  trig_async = glitch_go;
         la_pkg::TRIG_GLITCH_SRC: trig_async = glitch_trigger_src;
         la_pkg::TRIG_HS1:        trig_async = hs1;
      endcase
   end

   always_ff @(posedge observer_clk) begin
      if (reset) begin
         trig_sync  <= 2'b00;
         trig_delay <= 2'b00;
         capture_go <= 1'b0;
      end else begin
         trig_sync  <= {trig_sync[0], trig_async};
         trig_delay <= {trig_delay[0], trig_sync[1]};
         // Rising edge of the synchronized trigger, registered
         capture_go <= trig_delay[0] & ~trig_delay[1];
      end
   end

   a_go_single: assert property (
      @(posedge observer_clk) disable iff (reset)
      capture_go |=> !capture_go
   ) else $error("capture_go held for more than one cycle");

endmodule

//--- design/la_source_mux.sv
`timescale 1ns/1ns

module la_source_mux (
   input  logic                           observer_clk,
   input  logic                           reset,
   input  logic [1:0]                     capture_group,
   input  logic [la_pkg::NUM_CHANNELS-1:0] glitch_probes,
   input  logic [la_pkg::NUM_CHANNELS-1:0] front_io,
   input  logic [la_pkg::NUM_CHANNELS-1:0] user_io,
   output logic [la_pkg::NUM_CHANNELS-1:0] channel_samples
);

   logic [la_pkg::NUM_CHANNELS-1:0] test_pattern;
   logic [la_pkg::NUM_CHANNELS-1:0] group_sel;

   // Even channels high, odd channels low
   always_comb begin
      for (int i = 0; i < la_pkg::NUM_CHANNELS; i++) begin
         test_pattern[i] = (i % 2 == 0);
      end
   end

   always_comb begin
      case (capture_group)
         la_pkg::GROUP_GLITCH: begin
            group_sel = {1'b0, glitch_probes[la_pkg::NUM_CHANNELS-2:0]};  // Ch 8 not wired
         end
         la_pkg::GROUP_FRONT_IO: begin
            group_sel = {1'b0, front_io[la_pkg::NUM_CHANNELS-2:0]};
         end
         la_pkg::GROUP_USER_IO: begin
            group_sel = user_io;
         end
         la_pkg::GROUP_3: begin
            group_sel = test_pattern;  // Data path check with no probes
         end
      endcase
   end

   always_ff @(posedge observer_clk) begin
      if (reset) begin
         channel_samples <= '0;
      end else begin
         channel_samples <= group_sel;
      end
   end

endmodule

//--- design/la_capture.sv
`timescale 1ns/1ns

module la_capture (
   input  logic                           observer_clk,
   input  logic                           reset,
   input  logic                           capture_go,
   input  logic [la_pkg::NUM_CHANNELS-1:0] channel_samples,
   input  logic [3:0]                     read_select,
   input  logic [la_pkg::BYTECNT_SIZE-1:0] reg_bytecnt,
   output logic                           capturing,
   output logic                           capture_done,
   output logic [7:0]                     read_data
);

   logic [la_pkg::CAPTURE_DEPTH-1:0] records [la_pkg::NUM_CHANNELS];
   logic [la_pkg::COUNT_WIDTH-1:0]   sample_count;  // Samples held so far
   logic [la_pkg::CAPTURE_DEPTH-1:0] selected;
   logic [la_pkg::BYTECNT_SIZE+2:0]  byte_lsb;
   logic                             last_sample;

   // Next edge shifts in the final sample
   assign last_sample  = int'(sample_count) == la_pkg::CAPTURE_DEPTH - 1;
   assign capture_done = capturing && !capture_go && last_sample;

   always_ff @(posedge observer_clk) begin
      if (reset) begin
         capturing    <= 1'b0;
         sample_count <= '0;
         for (int ch = 0; ch < la_pkg::NUM_CHANNELS; ch++) begin
            records[ch] <= '0;
         end
      end else if (capture_go) begin
         // Sample 0 lands in the top bit and any capture in flight restarts
         capturing    <= 1'b1;
         sample_count <= {{(la_pkg::COUNT_WIDTH-1){1'b0}}, 1'b1};
         for (int ch = 0; ch < la_pkg::NUM_CHANNELS; ch++) begin
            records[ch] <= {channel_samples[ch], {(la_pkg::CAPTURE_DEPTH-1){1'b0}}};
         end
      end else if (capturing) begin
         for (int ch = 0; ch < la_pkg::NUM_CHANNELS; ch++) begin
            records[ch] <= {channel_samples[ch], records[ch][la_pkg::CAPTURE_DEPTH-1:1]};
         end
         if (last_sample) begin
            capturing <= 1'b0;
         end else begin
            sample_count <= sample_count + 1'b1;
         end
      end
   end

   // Readback selector
   assign byte_lsb = {reg_bytecnt, 3'b000};

   always_comb begin
      if (read_select < la_pkg::NUM_CHANNELS) begin
         selected = records[read_select];
      end else begin
         selected = la_pkg::FILL_PATTERN;
      end
   end

   assign read_data = selected[byte_lsb +: 8];

   a_count_range: assert property (
      @(posedge observer_clk) disable iff (reset)
      capturing |-> (sample_count != 0 && int'(sample_count) < la_pkg::CAPTURE_DEPTH)
   ) else $error("sample counter out of range during capture");

   // Done comes one full record after the pulse that started the capture
   a_done_timing: assert property (
      @(posedge observer_clk) disable iff (reset)
      capture_done |-> $past(capture_go, la_pkg::CAPTURE_DEPTH - 1)
   ) else $error("capture_done not CAPTURE_DEPTH-1 cycles after capture_go");

endmodule

//--- design/la_observer.sv
`timescale 1ns/1ns

module la_observer (
   input  logic                           observer_clk,
   input  logic                           reset,
   // Register port
   input  logic [7:0]                     reg_address,
   input  logic [la_pkg::BYTECNT_SIZE-1:0] reg_bytecnt,
   input  logic [7:0]                     reg_datai,
   input  logic                           reg_read,
   input  logic                           reg_write,
   output logic [7:0]                     reg_datao,
   // Probe groups
   input  logic [la_pkg::NUM_CHANNELS-1:0] glitch_probes,
   input  logic [la_pkg::NUM_CHANNELS-1:0] front_io,
   input  logic [la_pkg::NUM_CHANNELS-1:0] user_io,
   // Asynchronous triggers
   input  logic                           adc_capture_go,
   input  logic                           glitch_go,
   input  logic                           glitch_trigger_src,
   input  logic                           hs1
);

   logic [1:0]                      trigger_source;
   logic [1:0]                      capture_group;
   logic [3:0]                      read_select;
   logic                            capture_go;
   logic [la_pkg::NUM_CHANNELS-1:0] channel_samples;
   logic                            capturing;
   logic                            capture_done;
   logic [7:0]                      read_data;

   la_regs i_regs (
      .observer_clk   (observer_clk),
      .reset          (reset),
      .reg_address    (reg_address),
      .reg_datai      (reg_datai),
      .reg_read       (reg_read),
      .reg_write      (reg_write),
      .reg_bytecnt    (reg_bytecnt),
      .reg_datao      (reg_datao),
      .capturing      (capturing),
      .capture_done   (capture_done),
      .read_data      (read_data),
      .trigger_source (trigger_source),
      .capture_group  (capture_group),
      .read_select    (read_select)
   );

   la_trigger_sync i_trigger_sync (
      .observer_clk       (observer_clk),
      .reset              (reset),
      .trigger_source     (trigger_source),
      .adc_capture_go     (adc_capture_go),
      .glitch_go          (glitch_go),
      .glitch_trigger_src (glitch_trigger_src),
      .hs1                (hs1),
      .capture_go         (capture_go)
   );

   la_source_mux i_source_mux (
      .observer_clk    (observer_clk),
      .reset           (reset),
      .capture_group   (capture_group),
      .glitch_probes   (glitch_probes),
      .front_io        (front_io),
      .user_io         (user_io),
      .channel_samples (channel_samples)
   );

   la_capture i_capture (
      .observer_clk    (observer_clk),
      .reset           (reset),
      .capture_go      (capture_go),
      .channel_samples (channel_samples),
      .read_select     (read_select),
      .reg_bytecnt     (reg_bytecnt),
      .capturing       (capturing),
      .capture_done    (capture_done),
      .read_data       (read_data)
   );

endmodule

//--- tb/tb_la_observer.sv
`timescale 1ns/1ns

module tb_la_observer;

   localparam int DEPTH      = la_pkg::CAPTURE_DEPTH;
   localparam int NCH        = la_pkg::NUM_CHANNELS;
   localparam int BC         = la_pkg::BYTECNT_SIZE;
   localparam int MAX_CYCLES = 8 * (DEPTH + 40) * 6;  // Run limit from the test lengths

   logic             observer_clk = 1'b0;
   logic             reset;
   logic [7:0]       reg_address;
   logic [BC-1:0]    reg_bytecnt;
   logic [7:0]       reg_datai;
   logic             reg_read;
   logic             reg_write;
   logic [7:0]       reg_datao;
   logic [NCH-1:0]   glitch_probes;
   logic [NCH-1:0]   front_io;
   logic [NCH-1:0]   user_io;
   logic             adc_capture_go;
   logic             glitch_go;
   logic             glitch_trigger_src;
   logic             hs1;

   logic [31:0]      rng_state;
   int               cycle = 0;
   int               checks;
   int               errors;
   // Inputs as the DUT samples them at each rising edge
   logic [3*NCH-1:0] probe_hist [MAX_CYCLES];
   logic [3:0]       trig_hist  [MAX_CYCLES];

   la_observer i_dut (
      .observer_clk       (observer_clk),
      .reset              (reset),
      .reg_address        (reg_address),
      .reg_bytecnt        (reg_bytecnt),
      .reg_datai          (reg_datai),
      .reg_read           (reg_read),
      .reg_write          (reg_write),
      .reg_datao          (reg_datao),
      .glitch_probes      (glitch_probes),
      .front_io           (front_io),
      .user_io            (user_io),
      .adc_capture_go     (adc_capture_go),
      .glitch_go          (glitch_go),
      .glitch_trigger_src (glitch_trigger_src),
      .hs1                (hs1)
   );

   always #10 observer_clk = ~observer_clk;  // 20 ns period

   always @(posedge observer_clk) begin
      if (cycle >= MAX_CYCLES) begin
         $display("Timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
         $display("TB FAILED");
         $finish;
      end else begin
         probe_hist[cycle] <= {user_io, front_io, glitch_probes};
         trig_hist[cycle]  <= {hs1, glitch_trigger_src, glitch_go, adc_capture_go};  // By code
         cycle             <= cycle + 1;
      end
   end

   function automatic logic [31:0] next_random();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   // One clock, new random probe values every cycle
   task automatic next_cycle();
      logic [31:0] r;
      @(posedge observer_clk);
      r = next_random();
      glitch_probes <= r[8:0];
      front_io      <= r[17:9];
      user_io       <= r[26:18];
   endtask

   task automatic idle(input int n);
      repeat (n) next_cycle();
   endtask

   task automatic set_trigger(input logic [1:0] src, input logic level);
      case (src)
         la_pkg::TRIG_ADC:        adc_capture_go     <= level;
         la_pkg::TRIG_GLITCH_GO:  glitch_go          <= level;
         la_pkg::TRIG_GLITCH_SRC: glitch_trigger_src <= level;
         default:                 hs1                <= level;
      endcase
   endtask

   task automatic apply_reset();
      reset <= 1'b1;
      repeat (5) next_cycle();
      reset <= 1'b0;
      next_cycle();
   endtask

   task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
      next_cycle();
      reg_address <= addr;
      reg_datai   <= data;
      reg_write   <= 1'b1;
      next_cycle();
      reg_write <= 1'b0;
   endtask

   // Data loads at the edge after the strobe, sampled at the falling edge
   task automatic read_reg(input logic [7:0] addr, input logic [BC-1:0] bytecnt,
                           output logic [7:0] data);
      next_cycle();
      reg_address <= addr;
      reg_bytecnt <= bytecnt;
      reg_read    <= 1'b1;
      next_cycle();
      reg_read <= 1'b0;
      @(negedge observer_clk);
      data = reg_datao;
   endtask

   task automatic check_value(input logic [7:0] actual, input logic [7:0] expected,
                              input string what);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("ERROR at %0t ns: %s read %02h, expected %02h", $time, what, actual, expected);
      end
   endtask

   task automatic read_check(input logic [7:0] addr, input logic [BC-1:0] bytecnt,
                             input logic [7:0] expected, input string what);
      logic [7:0] data;
      read_reg(addr, bytecnt, data);
      check_value(data, expected, what);
   endtask

   task automatic check_idle();
      next_cycle();
      @(negedge observer_clk);
      check_value(reg_datao, 8'h00, "reg_datao after a cycle without read");
   endtask

   // Edge at which the DUT first samples the trigger high
   function automatic int find_rise(input int from, input logic [1:0] src);
      int found;
      found = -1;
      for (int k = from + 1; k < cycle; k++) begin
         if (found < 0 && trig_hist[k][src] && !trig_hist[k-1][src]) begin
            found = k;
         end
      end
      return found;
   endfunction

   // Bit i holds the probes sampled i edges after the first one
   function automatic logic [DEPTH-1:0] expected_record(input int first, input int group,
                                                        input int ch);
      logic [DEPTH-1:0] rec;
      logic [3*NCH-1:0] probes;
      rec = '0;
      for (int i = 0; i < DEPTH; i++) begin
         probes = probe_hist[first + i];
         if (ch < NCH - 1 || group == 2) begin  // Ch 8 unwired in groups 0 and 1
            rec[i] = probes[group * NCH + ch];
         end
      end
      return rec;
   endfunction

   task automatic run_capture(input logic [1:0] src, output int edge_at);
      logic [7:0] status;
      int         from;
      int         polls;
      idle(4);  // Synchronizer sees the trigger low first
      from = cycle;
      set_trigger(src, 1'b1);
      status = 8'h00;
      polls = 0;
      while (!status[1] && polls < 20) begin
         read_reg(la_pkg::REG_STATUS, '0, status);
         polls++;
      end
      if (status[1]) begin
         // Second read lands past the cycle where done drops
         read_check(la_pkg::REG_STATUS, '0, 8'h02, "status during capture");
      end else begin
         errors++;
         $display("Capture did not start: status never showed capturing after the trigger");
      end
      polls = 0;
      while (status[1] && polls < 2 * DEPTH) begin
         read_reg(la_pkg::REG_STATUS, '0, status);
         polls++;
      end
      check_value(status, 8'h01, "status after capture");
      next_cycle();
      set_trigger(src, 1'b0);
      edge_at = find_rise(from, src);
      if (edge_at < 0) begin
         errors++;
         $display("No rising trigger edge found in the input history");
      end
   endtask

   task automatic test_done(input string name, input int errors_before);
      $display("Test %-20s finished with %0d error(s)", name, errors - errors_before);
   endtask

   initial begin
      int               mark;
      int               edge_at;
      logic [1:0]       src;
      logic [31:0]      r;
      logic [7:0]       data;
      logic [DEPTH-1:0] rec;

      rng_state = 32'd5998;
      checks = 0;
      errors = 0;
      reset              <= 1'b1;
      reg_address        <= 8'h00;
      reg_bytecnt        <= '0;
      reg_datai          <= 8'h00;
      reg_read           <= 1'b0;
      reg_write          <= 1'b0;
      glitch_probes      <= '0;
      front_io           <= '0;
      user_io            <= '0;
      adc_capture_go     <= 1'b0;
      glitch_go          <= 1'b0;
      glitch_trigger_src <= 1'b0;
      hs1                <= 1'b0;
      apply_reset();

      mark = errors;
      read_check(la_pkg::REG_EXISTS, BC'(0), 8'h41, "exists byte 0");
      read_check(la_pkg::REG_EXISTS, BC'(1), 8'h4C, "exists byte 1");
      check_idle();
      read_check(la_pkg::REG_CAPTURE_DEPTH, BC'(0), 8'(DEPTH), "capture depth byte 0");
      read_check(la_pkg::REG_CAPTURE_DEPTH, BC'(1), 8'h00, "capture depth byte 1");
      read_check(la_pkg::REG_STATUS, '0, 8'h00, "status after reset");
      read_check(la_pkg::REG_TRIGGER_SOURCE, '0, 8'h00, "trigger source after reset");
      read_check(la_pkg::REG_CAPTURE_GROUP, '0, 8'h00, "capture group after reset");
      read_check(la_pkg::REG_READ_SELECT, '0, 8'h00, "channel 0 record after reset");
      read_check(8'h06, '0, 8'h00, "unknown address 06");
      read_check(8'hFF, '0, 8'h00, "unknown address ff");
      check_idle();
      test_done("reset_identity", mark);

      mark = errors;
      repeat (8) begin
         r = next_random();
         write_reg(la_pkg::REG_TRIGGER_SOURCE, {6'd0, r[1:0]});
         write_reg(la_pkg::REG_CAPTURE_GROUP, {6'd0, r[3:2]});
         read_check(la_pkg::REG_TRIGGER_SOURCE, '0, {6'd0, r[1:0]}, "trigger source readback");
         read_check(la_pkg::REG_CAPTURE_GROUP, '0, {6'd0, r[3:2]}, "capture group readback");
      end
      test_done("register_rw", mark);

      for (int g = 0; g < 3; g++) begin
         mark = errors;
         r = next_random();
         src = r[1:0];
         write_reg(la_pkg::REG_CAPTURE_GROUP, 8'(g));
         write_reg(la_pkg::REG_TRIGGER_SOURCE, {6'd0, src});
         run_capture(src, edge_at);
         if (edge_at >= 0) begin
            for (int ch = 0; ch < NCH; ch++) begin
               write_reg(la_pkg::REG_READ_SELECT, 8'(ch));
               rec = expected_record(edge_at + 3, g, ch);  // Sync and mux latency
               for (int b = 0; b < DEPTH / 8; b++) begin
                  read_check(la_pkg::REG_READ_SELECT, BC'(b), rec[b*8 +: 8],
                             $sformatf("group %0d channel %0d byte %0d", g, ch, b));
               end
            end
         end
         test_done($sformatf("capture_group_%0d", g), mark);
      end

      mark = errors;
      r = next_random();
      src = r[1:0];
      write_reg(la_pkg::REG_CAPTURE_GROUP, {6'd0, la_pkg::GROUP_3});
      write_reg(la_pkg::REG_TRIGGER_SOURCE, {6'd0, src});
      run_capture(src, edge_at);
      test_done("status_flags", mark);

      mark = errors;
      for (int sel = 0; sel < 16; sel++) begin
         write_reg(la_pkg::REG_READ_SELECT, 8'(sel));
         rec = la_pkg::FILL_PATTERN;
         for (int b = 0; b < DEPTH / 8; b++) begin
            if (sel >= NCH) begin
               data = rec[b*8 +: 8];
            end else begin
               data = (sel % 2 == 0) ? 8'hFF : 8'h00;  // Even channels high
            end
            read_check(la_pkg::REG_READ_SELECT, BC'(b), data,
                       $sformatf("select %0d byte %0d", sel, b));
         end
      end
      test_done("pattern_fill", mark);

      // Fresh reset so the sticky done bit starts clear
      mark = errors;
      apply_reset();
      r = next_random();
      src = r[1:0];
      write_reg(la_pkg::REG_TRIGGER_SOURCE, {6'd0, src});
      idle(4);
      set_trigger(src + 2'd1, 1'b1);
      idle(DEPTH / 2);
      read_check(la_pkg::REG_STATUS, '0, 8'h00, "status after unselected trigger");
      next_cycle();
      set_trigger(src + 2'd1, 1'b0);
      idle(4);
      test_done("unselected_trigger", mark);

      $display("Summary: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

//--- la_observer.f
design/la_pkg.sv
design/la_regs.sv
design/la_trigger_sync.sv
design/la_source_mux.sv
design/la_capture.sv
design/la_observer.sv
tb/tb_la_observer.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -f "$LOG" build.log
verilator --binary --assert --timescale 1ns/1ns -j 0 \
      --top-module tb_la_observer -f la_observer.f > build.log 2>&1 \
   && ./obj_dir/Vtb_la_observer > "$LOG" 2>&1 \
   || { cat build.log "$LOG" 2>/dev/null; echo "Build or run did not complete"; exit 1; }
cat "$LOG"
grep -q "TB PASSED" "$LOG" && echo "Result: pass" || { echo "Result: fail"; exit 1; }
